// File: source/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// buffer geometry
`define ROB_DEPTH 64
`define ROB_IDX_W 6

// index plus one wrap bit, so full and empty can be told apart
`define ROB_PTR_W 7

// four-wide front end
`define ROB_GRP_W 4

// retire window from the head
`define ROB_RET_W 4

// physical register number
`define PREG_W 6

// recovery pc kept per branch
`define RCVR_PC_W 16

`endif

// File: source/rob_pkg.sv
`include "rob_defs.svh"

package rob_pkg;

    // branch view of an entry payload
    typedef struct packed {
        logic [`RCVR_PC_W-1:0] rcvr_pc;
        logic                  pred_tkn;
        logic [1:0]            cond;
    } brnc_info_t;

    // register view, padded out to the branch view width
    typedef struct packed {
        logic [`RCVR_PC_W+3-`PREG_W-1:0] pad;
        logic [`PREG_W-1:0]              free_preg;
    } reg_info_t;

    // the entry's branch bit selects the view
    typedef union packed {
        brnc_info_t brnc;
        reg_info_t  reg_wr;
    } rob_payload_u;

    typedef struct packed {
        logic         brnc;
        logic         reg_wrt;
        rob_payload_u payload;
    } rob_slot_t;

    // slot 0 is the oldest instruction of the group
    typedef rob_slot_t [`ROB_GRP_W-1:0] alloc_grp_t;

    typedef struct packed {
        logic                  vld;
        logic [`ROB_IDX_W-1:0] idx;
    } cmpl_t;

    // a zero compare result means nothing arrives this cycle
    typedef struct packed {
        logic [`ROB_IDX_W-1:0] idx;
        logic [1:0]            cmp_rslt;
    } brnc_rslt_t;

    typedef struct packed {
        logic                  mis_pred;
        logic [`ROB_IDX_W-1:0] brnc_idx;
        logic [`RCVR_PC_W-1:0] rcvr_pc;
    } rcvr_t;

    typedef struct packed {
        logic [2:0]                         cnt;
        logic [`ROB_RET_W-1:0][`PREG_W-1:0] preg;
    } free_list_t;

    typedef struct packed {
        logic [`ROB_PTR_W-1:0] head_ptr;
        logic [2:0]            cnt;
    } retire_t;

endpackage

// File: source/rob_alloc.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_alloc (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc_vld,
    input  logic                  mis_pred,
    input  logic [`ROB_IDX_W-1:0] mis_pred_idx,
    input  rob_pkg::retire_t      retire,
    output logic [`ROB_PTR_W-1:0] tail_ptr,
    output logic                  alloc_fire,
    output logic                  rob_full_stll,
    output logic                  rob_empt
);

    logic [`ROB_PTR_W-1:0] occ;
    logic [`ROB_IDX_W-1:0] brnc_dist;
    logic [`ROB_PTR_W-1:0] rbk_tail;

    // wrap bit makes the subtraction exact up to a full buffer
    assign occ = tail_ptr - retire.head_ptr;

    // stall as soon as a whole group no longer fits
    assign rob_full_stll = (occ > (`ROB_DEPTH - `ROB_GRP_W));
    assign rob_empt      = (occ == '0);

    // a group in the same cycle as a flush belongs to the wrong path
    assign alloc_fire = alloc_vld && !rob_full_stll && !mis_pred;

    // branch lies in [head, tail), so measure it from the head
    assign brnc_dist = mis_pred_idx - retire.head_ptr[`ROB_IDX_W-1:0];
    assign rbk_tail  = retire.head_ptr + {1'b0, brnc_dist} + `ROB_PTR_W'(1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_ptr <= '0;
        end else if (mis_pred) begin
            // restart right behind the mispredicted branch
            tail_ptr <= rbk_tail;
        end else if (alloc_fire) begin
            tail_ptr <= tail_ptr + `ROB_PTR_W'(`ROB_GRP_W);
        end
    end

    // head from the retire stage must never overtake the tail
    a_occ_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (occ <= `ROB_DEPTH) && (`ROB_PTR_W'(retire.cnt) <= occ)
    ) else $error("rob occupancy out of range: %0d", occ);

endmodule

// File: source/rob_entries.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_entries (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      alloc_fire,
    input  logic [`ROB_PTR_W-1:0]                     tail_ptr,
    input  rob_pkg::alloc_grp_t                       alloc_grp,
    input  rob_pkg::cmpl_t                            mult_cmpl,
    input  rob_pkg::cmpl_t                            alu1_cmpl,
    input  rob_pkg::cmpl_t                            alu2_cmpl,
    input  rob_pkg::cmpl_t                            ld_cmpl,
    input  logic                                      brnc_ok,
    input  rob_pkg::rcvr_t                            rcvr,
    input  rob_pkg::retire_t                          retire,
    output logic [`ROB_DEPTH-1:0]                     vld_vec,
    output logic [`ROB_DEPTH-1:0]                     done_vld_vec,
    output logic [`ROB_DEPTH-1:0]                     brnc_vec,
    output logic [`ROB_DEPTH-1:0]                     reg_wrt_vec,
    output rob_pkg::rob_payload_u [`ROB_DEPTH-1:0]    payload
);

    localparam int IDX_W = `ROB_IDX_W;

    logic [`ROB_DEPTH-1:0]                 done_set;
    logic [`ROB_DEPTH-1:0]                 entry_clr;
    logic [`ROB_GRP_W-1:0][IDX_W-1:0]      wr_idx;
    logic [IDX_W-1:0]                      head_idx;
    logic [IDX_W-1:0]                      brnc_age;
    logic                                  cmpl_miss;

    assign head_idx = retire.head_ptr[IDX_W-1:0];
    assign brnc_age = rcvr.brnc_idx - head_idx;

    // group slots land on consecutive entries, wrapping at the top
    always_comb begin
        for (int k = 0; k < `ROB_GRP_W; k++) begin
            wr_idx[k] = tail_ptr[IDX_W-1:0] + IDX_W'(k);
        end
    end

    always_comb begin
        logic [IDX_W-1:0] age;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            age = IDX_W'(i) - head_idx;
            done_set[i] = (mult_cmpl.vld && mult_cmpl.idx == IDX_W'(i))
                       || (alu1_cmpl.vld && alu1_cmpl.idx == IDX_W'(i))
                       || (alu2_cmpl.vld && alu2_cmpl.idx == IDX_W'(i))
                       || (ld_cmpl.vld && ld_cmpl.idx == IDX_W'(i))
                       || ((brnc_ok || rcvr.mis_pred) && rcvr.brnc_idx == IDX_W'(i));
            // retired prefix, or anything younger than a mispredicted branch
            entry_clr[i] = (age < IDX_W'(retire.cnt))
                        || (rcvr.mis_pred && (age > brnc_age));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_vec      <= '0;
            done_vld_vec <= '0;
            brnc_vec     <= '0;
            reg_wrt_vec  <= '0;
        end else begin
            done_vld_vec <= (done_vld_vec | done_set) & ~entry_clr;
            vld_vec      <= vld_vec & ~entry_clr;
            if (alloc_fire) begin
                for (int k = 0; k < `ROB_GRP_W; k++) begin
                    vld_vec[wr_idx[k]]      <= 1'b1;
                    brnc_vec[wr_idx[k]]     <= alloc_grp[k].brnc;
                    reg_wrt_vec[wr_idx[k]]  <= alloc_grp[k].reg_wrt;
                    // nothing to wait for on these slots
                    done_vld_vec[wr_idx[k]] <= !(alloc_grp[k].brnc || alloc_grp[k].reg_wrt);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            for (int k = 0; k < `ROB_GRP_W; k++) begin
                payload[wr_idx[k]] <= alloc_grp[k].payload;
            end
        end
    end

    assign cmpl_miss = (mult_cmpl.vld && !vld_vec[mult_cmpl.idx])
                    || (alu1_cmpl.vld && !vld_vec[alu1_cmpl.idx])
                    || (alu2_cmpl.vld && !vld_vec[alu2_cmpl.idx])
                    || (ld_cmpl.vld && !vld_vec[ld_cmpl.idx]);

    // execution units only finish instructions that are still in flight
    a_cmpl_on_valid: assert property (
        @(posedge clk) disable iff (!rst_n) !cmpl_miss
    ) else $error("completion targets an invalid rob entry");

endmodule

// File: source/rob_branch_resolve.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_branch_resolve (
    input  rob_pkg::brnc_rslt_t                    brnc_rslt,
    input  logic [`ROB_DEPTH-1:0]                  vld_vec,
    input  logic [`ROB_DEPTH-1:0]                  brnc_vec,
    input  rob_pkg::rob_payload_u [`ROB_DEPTH-1:0] payload,
    output rob_pkg::rcvr_t                         rcvr,
    output logic                                   brnc_ok
);

    rob_pkg::brnc_info_t info;
    logic                is_brnc;
    logic                actual_tkn;

    // stored entry is a branch, so read the branch view
    assign info = payload[brnc_rslt.idx].brnc;

    always_comb begin
        is_brnc = (brnc_rslt.cmp_rslt != 2'b00)
               && vld_vec[brnc_rslt.idx]
               && brnc_vec[brnc_rslt.idx];

        // taken when the compare result matches the stored condition
        actual_tkn = (info.cond == brnc_rslt.cmp_rslt);

        rcvr.mis_pred = is_brnc && (info.pred_tkn != actual_tkn);
        rcvr.brnc_idx = brnc_rslt.idx;
        rcvr.rcvr_pc  = info.rcvr_pc;
        brnc_ok       = is_brnc && (info.pred_tkn == actual_tkn);

        // results only come back for branches still in flight
        a_rslt_on_brnc: assert ((brnc_rslt.cmp_rslt == 2'b00) || is_brnc)
            else $error("branch result for an entry that is not a valid branch");
    end

endmodule

// File: source/rob_retire.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_retire (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [`ROB_DEPTH-1:0]                  vld_vec,
    input  logic [`ROB_DEPTH-1:0]                  done_vld_vec,
    input  logic [`ROB_DEPTH-1:0]                  reg_wrt_vec,
    input  rob_pkg::rob_payload_u [`ROB_DEPTH-1:0] payload,
    output rob_pkg::retire_t                       retire,
    output rob_pkg::free_list_t                    free_list
);

    localparam int IDX_W = `ROB_IDX_W;

    logic [`ROB_PTR_W-1:0] head_ptr;
    logic [2:0]            ret_cnt;

    // find the longest ready prefix and pack freed regs along the way
    always_comb begin
        logic [IDX_W-1:0] idx;
        logic             stop;
        logic [2:0]       n_free;

        ret_cnt   = '0;
        n_free    = '0;
        stop      = 1'b0;
        free_list = '0;
        for (int k = 0; k < `ROB_RET_W; k++) begin
            idx = head_ptr[IDX_W-1:0] + IDX_W'(k);
            if (!stop && vld_vec[idx] && done_vld_vec[idx]) begin
                ret_cnt = ret_cnt + 3'd1;
                if (reg_wrt_vec[idx]) begin
                    free_list.preg[n_free[1:0]] = payload[idx].reg_wr.free_preg;
                    n_free = n_free + 3'd1;
                end
            end else begin
                // first unfinished entry blocks everything behind it
                stop = 1'b1;
            end
        end
        free_list.cnt = n_free;
    end

    assign retire.head_ptr = head_ptr;
    assign retire.cnt      = ret_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + `ROB_PTR_W'(ret_cnt);
        end
    end

    // valid entries always start at the head
    a_head_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        vld_vec[head_ptr[IDX_W-1:0]] || (vld_vec == '0)
    ) else $error("entry at the head is invalid while others are valid");

endmodule

// File: source/rob_top.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc_vld,
    input  rob_pkg::alloc_grp_t   alloc_grp,
    input  rob_pkg::cmpl_t        mult_cmpl,
    input  rob_pkg::cmpl_t        alu1_cmpl,
    input  rob_pkg::cmpl_t        alu2_cmpl,
    input  rob_pkg::cmpl_t        ld_cmpl,
    input  rob_pkg::brnc_rslt_t   brnc_rslt,
    output logic [`ROB_IDX_W-1:0] next_idx,
    output logic                  rob_full_stll,
    output logic                  rob_empt,
    output rob_pkg::rcvr_t        rcvr,
    output rob_pkg::free_list_t   free_list
);

    logic [`ROB_PTR_W-1:0]                  tail_ptr;
    logic                                   alloc_fire;
    logic                                   brnc_ok;
    logic [`ROB_DEPTH-1:0]                  vld_vec;
    logic [`ROB_DEPTH-1:0]                  done_vld_vec;
    logic [`ROB_DEPTH-1:0]                  brnc_vec;
    logic [`ROB_DEPTH-1:0]                  reg_wrt_vec;
    rob_pkg::rob_payload_u [`ROB_DEPTH-1:0] payload;
    rob_pkg::retire_t                       retire;

    assign next_idx = tail_ptr[`ROB_IDX_W-1:0];

    rob_alloc u_rob_alloc (
        .clk, .rst_n, .alloc_vld,
        .mis_pred(rcvr.mis_pred), .mis_pred_idx(rcvr.brnc_idx), .retire,
        .tail_ptr, .alloc_fire, .rob_full_stll, .rob_empt
    );

    rob_entries u_rob_entries (
        .clk, .rst_n, .alloc_fire, .tail_ptr, .alloc_grp,
        .mult_cmpl, .alu1_cmpl, .alu2_cmpl, .ld_cmpl,
        .brnc_ok, .rcvr, .retire,
        .vld_vec, .done_vld_vec, .brnc_vec, .reg_wrt_vec, .payload
    );

    rob_branch_resolve u_rob_branch_resolve (
        .brnc_rslt, .vld_vec, .brnc_vec, .payload, .rcvr, .brnc_ok
    );

    rob_retire u_rob_retire (
        .clk, .rst_n, .vld_vec, .done_vld_vec, .reg_wrt_vec, .payload,
        .retire, .free_list
    );

endmodule

// File: verification/rob_tb.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_tb;

    localparam int PERIOD     = 40;
    localparam int RST_CYC    = 4;
    localparam int WAIT_MAX   = 100;
    localparam int T_ALLOC    = 40;
    localparam int T_DRAIN    = 2 * `ROB_DEPTH + WAIT_MAX;
    localparam int T_BRANCH   = 20 + WAIT_MAX;
    localparam int RUN_CYCLES = RST_CYC + T_ALLOC + T_DRAIN + 2 * T_BRANCH;

    logic                  clk;
    logic                  rst_n;
    logic                  alloc_vld;
    rob_pkg::alloc_grp_t   alloc_grp;
    rob_pkg::cmpl_t        mult_cmpl;
    rob_pkg::cmpl_t        alu1_cmpl;
    rob_pkg::cmpl_t        alu2_cmpl;
    rob_pkg::cmpl_t        ld_cmpl;
    rob_pkg::brnc_rslt_t   brnc_rslt;
    logic [`ROB_IDX_W-1:0] next_idx;
    logic                  rob_full_stll;
    logic                  rob_empt;
    rob_pkg::rcvr_t        rcvr;
    rob_pkg::free_list_t   free_list;

    int                    seed;
    int                    seq;
    int                    bseq;
    logic [1:0]            cond;
    // reference queues in program order with seq counting like the tail pointer
    int                    pend[$];
    int                    exp_seq[$];
    logic [`PREG_W-1:0]    exp_preg[$];
    logic [`RCVR_PC_W-1:0] bpc [`ROB_DEPTH];

    rob_top u_rob_top (
        .clk, .rst_n, .alloc_vld, .alloc_grp,
        .mult_cmpl, .alu1_cmpl, .alu2_cmpl, .ld_cmpl, .brnc_rslt,
        .next_idx, .rob_full_stll, .rob_empt, .rcvr, .free_list
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        a_value: assert (got === exp)
            else fail_run($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                                    $time, name, got, exp));
    endtask

    task automatic alloc_group(input logic [3:0] brnc_mask, input logic [3:0] reg_mask,
                               input logic pred, input logic [1:0] br_cond);
        rob_pkg::alloc_grp_t grp;
        grp = '0;
        for (int k = 0; k < `ROB_GRP_W; k++) begin
            grp[k].brnc    = brnc_mask[k];
            grp[k].reg_wrt = reg_mask[k];
            if (brnc_mask[k]) begin
                grp[k].payload.brnc.rcvr_pc  = `RCVR_PC_W'($random(seed));
                grp[k].payload.brnc.pred_tkn = pred;
                grp[k].payload.brnc.cond     = br_cond;
                bpc[(seq + k) % `ROB_DEPTH]  = grp[k].payload.brnc.rcvr_pc;
            end else if (reg_mask[k]) begin
                grp[k].payload.reg_wr.free_preg = `PREG_W'($random(seed));
            end
        end
        @(negedge clk);
        check_eq("rob_full_stll", rob_full_stll, 0);
        alloc_vld = 1'b1;
        alloc_grp = grp;
        @(negedge clk);
        alloc_vld = 1'b0;
        check_eq("next_idx", next_idx, (seq + `ROB_GRP_W) % `ROB_DEPTH);
        for (int k = 0; k < `ROB_GRP_W; k++) begin
            if (reg_mask[k]) begin
                pend.push_back(seq + k);
                exp_seq.push_back(seq + k);
                exp_preg.push_back(grp[k].payload.reg_wr.free_preg);
            end
        end
        seq = seq + `ROB_GRP_W;
    endtask

    task automatic shuffle_pending();
        int j;
        int t;
        for (int i = pend.size() - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            t = pend[i];
            pend[i] = pend[j];
            pend[j] = t;
        end
    endtask

    // one to four completions per cycle across the four ports
    task automatic complete_pending();
        rob_pkg::cmpl_t c [4];
        int             n;
        while (pend.size() > 0) begin
            @(negedge clk);
            n = 1 + $unsigned($random(seed)) % 4;
            for (int p = 0; p < 4; p++) begin
                c[p] = '0;
                if (p < n && pend.size() > 0) begin
                    c[p].vld = 1'b1;
                    c[p].idx = `ROB_IDX_W'(pend.pop_front() % `ROB_DEPTH);
                end
            end
            mult_cmpl = c[0];
            alu1_cmpl = c[1];
            alu2_cmpl = c[2];
            ld_cmpl   = c[3];
        end
        @(negedge clk);
        mult_cmpl = '0;
        alu1_cmpl = '0;
        alu2_cmpl = '0;
        ld_cmpl   = '0;
    endtask

    task automatic resolve_branch(input int br_seq, input logic [1:0] cmp, input logic exp_mis);
        logic [`ROB_IDX_W-1:0] bidx;
        bidx = `ROB_IDX_W'(br_seq % `ROB_DEPTH);
        @(negedge clk);
        brnc_rslt.idx      = bidx;
        brnc_rslt.cmp_rslt = cmp;
        #(PERIOD / 4);
        check_eq("rcvr.mis_pred", rcvr.mis_pred, exp_mis);
        if (exp_mis) begin
            check_eq("rcvr.rcvr_pc", rcvr.rcvr_pc, bpc[bidx]);
            check_eq("rcvr.brnc_idx", rcvr.brnc_idx, bidx);
        end
        @(negedge clk);
        brnc_rslt = '0;
        if (exp_mis) begin
            check_eq("next_idx", next_idx, (bidx + 1) % `ROB_DEPTH);
        end
    endtask

    // drop everything younger than the branch from the reference
    task automatic squash_younger(input int br_seq);
        while (pend.size() > 0 && pend[$] > br_seq) begin
            void'(pend.pop_back());
        end
        while (exp_seq.size() > 0 && exp_seq[$] > br_seq) begin
            void'(exp_seq.pop_back());
            void'(exp_preg.pop_back());
        end
    endtask

    task automatic wait_empty();
        int n;
        n = 0;
        while (!rob_empt) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                fail_run("reorder buffer did not drain to empty");
            end
        end
    endtask

    // freed registers must match the reference in program order
    always @(negedge clk) begin
        for (int k = 0; k < `ROB_RET_W; k++) begin
            if (k < free_list.cnt) begin
                if (exp_preg.size() == 0) begin
                    fail_run("free list reports a register with none outstanding");
                end
                check_eq($sformatf("free_list.preg[%0d]", k), free_list.preg[k],
                         exp_preg.pop_front());
                void'(exp_seq.pop_front());
            end else begin
                check_eq($sformatf("free_list.preg[%0d]", k), free_list.preg[k], 0);
            end
        end
    end

    a_full_empty_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rob_full_stll && rob_empt))
        else fail_run("buffer reports full and empty at once");

    a_free_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
        free_list.cnt <= `ROB_RET_W)
        else fail_run("free list count above the retire width");

    a_pulse_needs_rslt: assert property (@(posedge clk) disable iff (!rst_n)
        rcvr.mis_pred |-> brnc_rslt.cmp_rslt != 2'b00)
        else fail_run("misprediction pulse without a branch result");

    initial begin
        #(RUN_CYCLES * PERIOD + 100 * PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        seed      = 68;
        seq       = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        alloc_vld = 1'b0;
        alloc_grp = '0;
        mult_cmpl = '0;
        alu1_cmpl = '0;
        alu2_cmpl = '0;
        ld_cmpl   = '0;
        brnc_rslt = '0;
        repeat (RST_CYC) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("rob_empt", rob_empt, 1);
        check_eq("rob_full_stll", rob_full_stll, 0);
        check_eq("rcvr.mis_pred", rcvr.mis_pred, 0);
        check_eq("free_list.cnt", free_list.cnt, 0);
        check_eq("next_idx", next_idx, 0);

        // fill up with register writers that cannot retire yet
        repeat (`ROB_DEPTH / `ROB_GRP_W) alloc_group(4'h0, 4'hF, 1'b0, 2'b00);
        check_eq("rob_full_stll", rob_full_stll, 1);
        @(negedge clk);
        alloc_vld = 1'b1;
        @(negedge clk);
        alloc_vld = 1'b0;
        check_eq("next_idx", next_idx, seq % `ROB_DEPTH);

        shuffle_pending();
        complete_pending();
        wait_empty();
        check_eq("outstanding free registers", exp_preg.size(), 0);

        // a correctly predicted branch retires normally
        bseq = seq + 1;
        cond = 2'(1 + $unsigned($random(seed)) % 3);
        alloc_group(4'b0010, 4'b0101, 1'b1, cond);
        resolve_branch(bseq, cond, 1'b0);
        complete_pending();
        wait_empty();

        // branch predicted not taken resolves taken and squashes younger slots
        bseq = seq + 1;
        cond = 2'(1 + $unsigned($random(seed)) % 3);
        alloc_group(4'b0010, 4'b1101, 1'b0, cond);
        alloc_group(4'h0, 4'hF, 1'b0, 2'b00);
        resolve_branch(bseq, cond, 1'b1);
        squash_younger(bseq);
        seq = bseq + 1;
        complete_pending();
        wait_empty();
        check_eq("outstanding free registers", exp_preg.size(), 0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: rob_top.f
+incdir+source
source/rob_pkg.sv
source/rob_alloc.sv
source/rob_entries.sv
source/rob_branch_resolve.sv
source/rob_retire.sv
source/rob_top.sv
verification/rob_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLIST      := rob_top.f
TOP        := rob_tb
RTL_TOP    := rob_top
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
